// ==== src.f ====
wsg_pkg.sv
wsg_voice_if.sv
wsg_clock_div.sv
wsg_channel_regs.sv
wsg_voice_sequencer.sv
wsg_phase_accum.sv
wsg_mixer.sv
wsg_top.sv
tb_wsg.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and judges the result from the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_wsg -o tb_wsg_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_wsg_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "FAIL: see errors above" "$log"; then
	exit 1
fi

if ! grep -q "PASS: all tests" "$log"; then
	echo "simulation ended without a result line"
	exit 1
fi

exit 0

// ==== tb_wsg.sv ====
`timescale 1ns/1ns

module tb_wsg;
	import wsg_pkg::*;

	localparam int step_log2   = 4;	// short voice slots keep the run brief
	localparam int sample_log2 = step_log2 + 3;
	localparam int wave_limit  = (2 ** (step_log2 + 1)) + 4;	// cycles allowed per wave_clk rise

	logic       MCLK;
	logic       reset;
	logic [5:0] addr;
	logic [7:0] data;
	logic       we;
	logic       snd_enable;
	logic       wave_clk;
	logic [7:0] wave_ad;
	logic [3:0] wave_dt;
	logic [7:0] sout;

	sample_t rom [256];	// external waveform ROM
	integer  seed;

	// software copy of the generator state
	logic [sample_log2:0] m_cnt;
	voice_t     m_idx;
	voice_t     m_mix_idx;
	logic       m_started;
	logic       m_active;
	freq_t      m_freq [num_voices];
	freq_t      m_acc  [num_voices];
	vol_t       m_vol  [num_voices];
	wave_sel_t  m_wsel [num_voices];
	vol_t       m_vol_q;
	logic [7:0] m_wave_ad;
	logic [7:0] m_run_sum;
	logic [7:0] m_total;
	logic [7:0] m_sout;
	logic       m_wave_clk;

	string      cur_test;
	logic       checking;
	logic       timed_out;
	logic [7:0] last_ad;
	int         ad_steps;
	int         total_errors;
	int         test_start_errors;
	int         passed;
	int         failed;

	wsg_top #(
		.step_div_log2   (step_log2),
		.sample_div_log2 (sample_log2)
	) dut_i (
		.MCLK       (MCLK),
		.reset      (reset),
		.addr       (addr),
		.data       (data),
		.we         (we),
		.snd_enable (snd_enable),
		.wave_clk   (wave_clk),
		.wave_ad    (wave_ad),
		.wave_dt    (wave_dt),
		.sout       (sout)
	);

	assign wave_dt = $isunknown(wave_ad) ? 4'h0 : rom[wave_ad];	// ROM answers combinationally

	initial begin
		MCLK = 1'b0;
		forever #2 MCLK = ~MCLK;
	end

	function automatic logic [6:0] sat7(input logic [7:0] total);
		return (total > 8'd127) ? 7'h7f : total[6:0];
	endfunction

	function automatic void model_reset();
		m_cnt      = '0;
		m_idx      = '0;
		m_mix_idx  = '0;
		m_started  = 1'b0;
		m_active   = 1'b0;
		m_vol_q    = '0;
		m_wave_ad  = '0;
		m_run_sum  = '0;
		m_total    = '0;
		m_sout     = '0;
		m_wave_clk = 1'b0;
		for (int i = 0; i < num_voices; i++) begin
			m_freq[i] = '0;
			m_acc[i]  = '0;
			m_vol[i]  = '0;
			m_wsel[i] = '0;
		end
	endfunction

	// one MCLK edge of the reference, every update uses the values from before the edge
	function automatic void model_clock();
		logic       tick;
		logic       smp;
		logic [7:0] product;
		logic [7:0] contrib;
		tick = (m_cnt[step_log2-1:0] == '1);
		smp  = (m_cnt[sample_log2-1:0] == '1);
		if (smp) begin
			m_sout = snd_enable ? {sat7(m_total), 1'b0} : 8'h00;	// total of the last full round
		end
		if (tick) begin
			product = 8'(rom[m_wave_ad]) * 8'(m_vol_q);
			contrib = m_active ? (product >> 4) : 8'h00;
			if (m_started && (m_mix_idx == 3'd0)) begin
				m_total   = m_run_sum;
				m_run_sum = contrib;
			end else begin
				m_run_sum = m_run_sum + contrib;
			end
			m_vol_q   = m_vol[m_idx];
			m_active  = (m_freq[m_idx] != '0);
			m_wave_ad = {m_wsel[m_idx], m_acc[m_idx][19:15]};	// phase before the add
			m_acc[m_idx] = m_acc[m_idx] + m_freq[m_idx];
			m_mix_idx = m_idx;
			m_idx     = voice_t'(m_idx + 3'd1);
			m_started = 1'b1;
		end
		if (we && m_cnt[0]) begin
			case (addr[2:0])
				3'd3: m_vol[addr[5:3]] = data[3:0];
				3'd4: m_freq[addr[5:3]][7:0] = data;
				3'd5: m_freq[addr[5:3]][15:8] = data;
				3'd6: begin
					m_freq[addr[5:3]][19:16] = data[3:0];
					m_wsel[addr[5:3]] = data[6:4];
				end
				default: ;
			endcase
		end
		m_cnt      = m_cnt + 1'b1;
		m_wave_clk = m_cnt[step_log2];	// the count bit just above one voice slot
	endfunction

	always @(posedge MCLK) begin
		if (reset) begin
			model_reset();
		end else begin
			model_clock();
		end
	end

	task automatic check_sout(input logic [7:0] expected, input logic [7:0] actual);
		if (actual !== expected) begin
			total_errors++;
			if (total_errors - test_start_errors <= 10) begin
				$display("mismatch %s sout expected %0d actual %0d", cur_test, expected, actual);
			end
		end
	endtask

	task automatic check_wave_ad(input logic [7:0] expected, input logic [7:0] actual);
		if (actual !== expected) begin
			total_errors++;
			if (total_errors - test_start_errors <= 10) begin
				$display("mismatch %s wave_ad expected 0x%02h actual 0x%02h",
					cur_test, expected, actual);
			end
		end
	endtask

	task automatic check_wave_clk(input logic expected, input logic actual);
		if (actual !== expected) begin
			total_errors++;
			if (total_errors - test_start_errors <= 10) begin
				$display("mismatch %s wave_clk expected %0b actual %0b",
					cur_test, expected, actual);
			end
		end
	endtask

	// both sides are stable half a cycle after the rising edge
	always @(negedge MCLK) begin
		if (checking) begin
			check_sout(m_sout, sout);
			check_wave_ad(m_wave_ad, wave_ad);
			check_wave_clk(m_wave_clk, wave_clk);
			if (wave_ad != last_ad) ad_steps++;
			last_ad = wave_ad;
		end
	end

	task automatic write_reg(input logic [5:0] a, input wsg_reg_data_u d);
		addr = a;
		data = d;
		we   = 1'b1;
		@(negedge MCLK);	// two cycles always cover one write_en pulse
		@(negedge MCLK);
		we   = 1'b0;
	endtask

	task automatic set_voice(input voice_t v, input freq_t f, input vol_t vl, input wave_sel_t ws);
		wsg_reg_data_u d;
		d.freq_byte = f[7:0];
		write_reg({v, reg_freq_lo}, d);
		d.freq_byte = f[15:8];
		write_reg({v, reg_freq_mid}, d);
		d.ctrl.spare    = 1'b0;
		d.ctrl.wave_sel = ws;
		d.ctrl.nibble   = f[19:16];
		write_reg({v, reg_freq_hi}, d);
		d.ctrl.nibble = vl;
		write_reg({v, reg_vol}, d);
	endtask

	// a sample period is four wave_clk periods
	task automatic wait_samples(input int n);
		int   rises;
		int   cycles;
		logic prev;
		rises  = 0;
		cycles = 0;
		prev   = wave_clk;
		while (!timed_out && (rises < 4 * n)) begin
			@(negedge MCLK);
			cycles++;
			if (wave_clk && !prev) rises++;
			prev = wave_clk;
			if (cycles > 4 * n * wave_limit) begin
				timed_out = 1'b1;
				$display("timeout: wave_clk stopped toggling during %s", cur_test);
			end
		end
	endtask

	task automatic run_test(input int num);
		test_start_errors = total_errors;
		case (num)
			1: begin
				cur_test = "reset_idle";
				wait_samples(1);
				check_sout(8'h00, sout);
				check_wave_ad(8'h00, wave_ad);
			end
			2: begin
				cur_test = "single_voice_address";
				set_voice(3'd1, 20'h1_8000, 4'd0, 3'd5);
				wait_samples(4);
			end
			3: begin
				cur_test = "single_voice_output";
				set_voice(3'd1, 20'h1_8000, 4'd12, 3'd5);
				wait_samples(4);
			end
			4: begin
				cur_test = "all_voices_full_volume";
				for (int v = 0; v < num_voices; v++) begin
					set_voice(voice_t'(v), freq_t'((v + 1) * 20'h0_9000), 4'd15, wave_sel_t'(v));
				end
				wait_samples(4);
				if (sout == 8'h00) begin
					total_errors++;
					$display("sout stayed at zero with all eight voices playing");
				end
			end
			5: begin
				cur_test = "zero_freq_voice";
				set_voice(3'd2, 20'h0_0000, 4'd15, 3'd2);
				wait_samples(3);
			end
			default: begin
				cur_test   = "sound_disabled";
				snd_enable = 1'b0;
				ad_steps   = 0;
				wait_samples(2);
				check_sout(8'h00, sout);
				if (ad_steps == 0) begin
					total_errors++;
					$display("wave_ad did not step while the sound output was off");
				end
			end
		endcase
		if (timed_out || (total_errors != test_start_errors)) begin
			failed++;
			$display("test %0d %s: failed with %0d errors", num, cur_test,
				total_errors - test_start_errors);
		end else begin
			passed++;
			$display("test %0d %s: ok", num, cur_test);
		end
	endtask

	initial begin
		reset        = 1'b1;
		addr         = '0;
		data         = '0;
		we           = 1'b0;
		snd_enable   = 1'b1;
		checking     = 1'b0;
		timed_out    = 1'b0;
		last_ad      = '0;
		ad_steps     = 0;
		total_errors = 0;
		passed       = 0;
		failed       = 0;
		cur_test     = "reset";
		seed         = 31;
		for (int i = 0; i < 256; i++) begin
			rom[i] = sample_t'($random(seed));
		end
		repeat (3) @(negedge MCLK);
		reset    = 1'b0;
		checking = 1'b1;
		for (int t = 1; (t <= 6) && !timed_out; t++) begin
			run_test(t);
		end
		$display("tests passed %0d, failed %0d, errors %0d", passed, failed, total_errors);
		if (timed_out || (total_errors != 0)) begin
			$display("FAIL: see errors above");
		end else begin
			$display("PASS: all tests");
		end
		$finish;
	end

endmodule

// ==== wsg_top.sv ====
`timescale 1ns/1ns

module wsg_top #(
	parameter int step_div_log2   = 7,
	parameter int sample_div_log2 = 10	// must be step_div_log2 + 3
) (
	input  logic       MCLK,
	input  logic       reset,
	input  logic [5:0] addr,
	input  logic [7:0] data,
	input  logic       we,
	input  logic       snd_enable,
	output logic       wave_clk,
	output logic [7:0] wave_ad,
	input  logic [3:0] wave_dt,
	output logic [7:0] sout
);
	import wsg_pkg::*;

	logic write_en;
	logic step_tick;
	logic sample_tick;
	logic fetch;
	logic round_start;
	logic voice_active;

	// settings of the voice currently being stepped
	wsg_voice_if voice_bus ();

	wsg_clock_div #(
		.step_div_log2   (step_div_log2),
		.sample_div_log2 (sample_div_log2)
	) clock_div_i (
		.MCLK        (MCLK),
		.reset       (reset),
		.write_en    (write_en),
		.step_tick   (step_tick),
		.sample_tick (sample_tick),
		.wave_clk    (wave_clk)
	);

	wsg_channel_regs channel_regs_i (
		.MCLK     (MCLK),
		.reset    (reset),
		.write_en (write_en),
		.addr     (addr),
		.data     (wsg_reg_data_u'(data)),
		.we       (we),
		.voice    (voice_bus.regs)
	);

	wsg_voice_sequencer voice_sequencer_i (
		.MCLK        (MCLK),
		.reset       (reset),
		.step_tick   (step_tick),
		.voice       (voice_bus.seq),
		.round_start (round_start),
		.fetch       (fetch)
	);

	wsg_phase_accum phase_accum_i (
		.MCLK         (MCLK),
		.reset        (reset),
		.fetch        (fetch),
		.voice        (voice_bus.accum),
		.wave_ad      (wave_ad),
		.voice_active (voice_active)
	);

	// the mixer takes the volume straight off the bus and latches it itself
	wsg_mixer mixer_i (
		.MCLK         (MCLK),
		.reset        (reset),
		.step_tick    (step_tick),
		.sample_tick  (sample_tick),
		.round_start  (round_start),
		.voice_active (voice_active),
		.vol          (voice_bus.vol),
		.wave_dt      (wave_dt),
		.snd_enable   (snd_enable),
		.sout         (sout)
	);

endmodule

// ==== wsg_mixer.sv ====
`timescale 1ns/1ns

module wsg_mixer (
	input  logic             MCLK,
	input  logic             reset,
	input  logic             step_tick,
	input  logic             sample_tick,
	input  logic             round_start,
	input  logic             voice_active,
	input  wsg_pkg::vol_t    vol,
	input  wsg_pkg::sample_t wave_dt,
	input  logic             snd_enable,
	output logic [7:0]       sout
);
	import wsg_pkg::*;

	vol_t       vol_q;	// volume of the voice whose sample is on wave_dt
	logic [7:0] product;
	logic [7:0] contrib;
	logic [7:0] run_sum;
	logic [7:0] round_total;
	logic [6:0] mix_sat;

	assign product = wave_dt * vol_q;
	assign contrib = voice_active ? {4'h0, product[7:4]} : 8'h00;	// keep the top nibble

	// clamp to 7 bits once the round total reaches 128
	assign mix_sat = round_total[6:0] | {7{round_total[7]}};

	always_ff @(posedge MCLK) begin
		if (reset) begin
			vol_q       <= '0;
			run_sum     <= '0;
			round_total <= '0;
			sout        <= '0;
		end else begin
			if (step_tick) begin
				// the voice fetched now is the one mixed on the next tick
				vol_q <= vol;
				if (round_start) begin
					round_total <= run_sum;
					run_sum     <= contrib;	// voice 0 opens the new round
				end else begin
					run_sum <= run_sum + contrib;
				end
			end
			if (sample_tick) begin
				sout <= snd_enable ? {mix_sat, 1'b0} : 8'h00;
			end
		end
	end

endmodule

// ==== wsg_phase_accum.sv ====
`timescale 1ns/1ns

module wsg_phase_accum (
	input  logic        MCLK,
	input  logic        reset,
	input  logic        fetch,
	wsg_voice_if.accum  voice,
	output logic [7:0]  wave_ad,
	output logic        voice_active
);
	import wsg_pkg::*;

	freq_t acc [num_voices];
	freq_t acc_cur;

	assign acc_cur = acc[voice.index];

	always_ff @(posedge MCLK) begin
		if (reset) begin
			for (int i = 0; i < num_voices; i++) begin
				acc[i] <= '0;
			end
			wave_ad      <= '0;
			voice_active <= 1'b0;
		end else if (fetch) begin
			acc[voice.index] <= acc_cur + voice.freq;	// wraps freely at 20 bits

			// the address takes the phase from before this step
			wave_ad      <= {voice.wave_sel, acc_cur[19:15]};

			// a silent voice keeps stepping its address but adds no sound
			voice_active <= (voice.freq != '0);
		end
	end

endmodule

// ==== wsg_voice_sequencer.sv ====
`timescale 1ns/1ns

module wsg_voice_sequencer (
	input  logic     MCLK,
	input  logic     reset,
	input  logic     step_tick,
	wsg_voice_if.seq voice,
	output logic     round_start,
	output logic     fetch
);
	import wsg_pkg::*;

	// idle until the first tick, fetch while an address has just gone out,
	// settle while the ROM data is held for the mixer
	localparam logic [1:0] st_idle   = 2'd0;
	localparam logic [1:0] st_fetch  = 2'd1;
	localparam logic [1:0] st_settle = 2'd2;

	logic [1:0] state;
	logic [1:0] state_next;
	voice_t     mix_voice;	// voice whose sample is on wave_dt

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				if (step_tick) begin
					state_next = st_fetch;
				end
			end
			st_fetch: begin
				state_next = step_tick ? st_fetch : st_settle;	// back-to-back ticks stay here
			end
			st_settle: begin
				if (step_tick) begin
					state_next = st_fetch;
				end
			end
			default: state_next = st_idle;
		endcase
	end

	always_ff @(posedge MCLK) begin
		if (reset) begin
			state       <= st_idle;
			voice.index <= '0;
			mix_voice   <= '0;
		end else begin
			state <= state_next;
			if (step_tick) begin
				mix_voice   <= voice.index;	// fetched now, mixed on the next tick
				voice.index <= voice_t'(voice.index + 1'b1);
			end
		end
	end

	// every tick is an accumulator step
	assign fetch = step_tick;

	// no address has gone out while idle, so there is nothing to mix yet
	assign round_start = step_tick && (state != st_idle) && (mix_voice == '0);

endmodule

// ==== wsg_channel_regs.sv ====
`timescale 1ns/1ns

module wsg_channel_regs (
	input  logic                   MCLK,
	input  logic                   reset,
	input  logic                   write_en,
	input  logic [5:0]             addr,
	input  wsg_pkg::wsg_reg_data_u data,
	input  logic                   we,
	wsg_voice_if.regs              voice
);
	import wsg_pkg::*;

	logic [7:0] freq_lo  [num_voices];
	logic [7:0] freq_mid [num_voices];
	logic [3:0] freq_hi  [num_voices];
	vol_t       vol      [num_voices];
	wave_sel_t  wave_sel [num_voices];

	voice_t     wr_voice;
	logic [2:0] wr_reg;

	assign wr_voice = addr[5:3];	// each voice owns eight addresses
	assign wr_reg   = addr[2:0];

	always_ff @(posedge MCLK) begin
		if (reset) begin
			for (int i = 0; i < num_voices; i++) begin
				freq_lo[i]  <= '0;
				freq_mid[i] <= '0;
				freq_hi[i]  <= '0;
				vol[i]      <= '0;
				wave_sel[i] <= '0;
			end
		end else if (write_en && we) begin
			case (wr_reg)
				reg_vol:      vol[wr_voice]      <= data.ctrl.nibble;
				reg_freq_lo:  freq_lo[wr_voice]  <= data.freq_byte;
				reg_freq_mid: freq_mid[wr_voice] <= data.freq_byte;
				reg_freq_hi: begin
					// the waveform select shares the byte with the top nibble
					freq_hi[wr_voice]  <= data.ctrl.nibble;
					wave_sel[wr_voice] <= data.ctrl.wave_sel;
				end
				default: ;	// offsets 0 to 2 and 7 hold nothing
			endcase
		end
	end

	// settings of the voice the sequencer points at
	assign voice.freq     = {freq_hi[voice.index], freq_mid[voice.index], freq_lo[voice.index]};
	assign voice.vol      = vol[voice.index];
	assign voice.wave_sel = wave_sel[voice.index];

endmodule

// ==== wsg_clock_div.sv ====
`timescale 1ns/1ns

module wsg_clock_div #(
	parameter int step_div_log2   = 7,
	parameter int sample_div_log2 = 10
) (
	input  logic MCLK,
	input  logic reset,
	output logic write_en,
	output logic step_tick,
	output logic sample_tick,
	output logic wave_clk
);

	// one extra bit above the sample period gives a full cycle of the counter
	localparam int cnt_w = sample_div_log2 + 1;

	logic [cnt_w-1:0] cnt;

	always_ff @(posedge MCLK) begin
		if (reset) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign write_en    = cnt[0];	// every odd count
	assign step_tick   = &cnt[step_div_log2-1:0];	// once per voice slot
	assign sample_tick = &cnt[sample_div_log2-1:0];	// once per round of eight

	// toggles at half the step rate, the ROM side can use it as a strobe
	assign wave_clk    = cnt[step_div_log2];

endmodule

// ==== wsg_voice_if.sv ====
`timescale 1ns/1ns

interface wsg_voice_if;
	import wsg_pkg::*;

	voice_t    index;	// the voice being fetched, owned by the sequencer

	// settings of that voice, looked up by the register file
	freq_t     freq;
	vol_t      vol;
	wave_sel_t wave_sel;

	modport regs (
		input  index,
		output freq,
		output vol,
		output wave_sel
	);

	modport seq (
		output index
	);

	modport accum (
		input index,
		input freq,
		input wave_sel
	);

endinterface

// ==== wsg_pkg.sv ====
package wsg_pkg;

	// eight voices are served in turn, one per step tick
	localparam int num_voices = 8;

	typedef logic [2:0]  voice_t;
	typedef logic [19:0] freq_t;	// frequency increment and phase accumulator width
	typedef logic [3:0]  vol_t;
	typedef logic [2:0]  wave_sel_t;	// picks one of eight 32-sample waveforms
	typedef logic [3:0]  sample_t;	// one ROM nibble

	// register offsets inside a voice's block of eight addresses
	localparam logic [2:0] reg_vol      = 3'd3;
	localparam logic [2:0] reg_freq_lo  = 3'd4;
	localparam logic [2:0] reg_freq_mid = 3'd5;
	localparam logic [2:0] reg_freq_hi  = 3'd6;

	// a write byte is a plain frequency byte for the low and middle
	// frequency registers, and a control byte for volume and the top nibble
	typedef union packed {
		logic [7:0] freq_byte;
		struct packed {
			logic       spare;	// bit 7 is not stored
			wave_sel_t  wave_sel;
			logic [3:0] nibble;	// high frequency nibble or volume
		} ctrl;
	} wsg_reg_data_u;

endpackage
